/* dir_if.sv */
`timescale 1ns/1ps

interface dir_if;
    import route_pkg::*;

    logic       valid;  // request sits in the second stage
    route_alg_e alg;
    dir_flags_t flags;

    modport producer (
        output valid,
        output alg,
        output flags
    );

    modport consumer (
        input valid,
        input alg,
        input flags
    );

endinterface

/* mesh_dir_stage.sv */
`timescale 1ns/1ps

module mesh_dir_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  route_req,
    input  route_pkg::route_alg_e route_alg,
    input  mesh_pkg::x_coord_t    current_x,
    input  mesh_pkg::y_coord_t    current_y,
    input  mesh_pkg::x_coord_t    dest_x,
    input  mesh_pkg::y_coord_t    dest_y,
    dir_if.producer               dir
);
    import mesh_pkg::*;
    import route_pkg::*;

    dir_flags_t  flags_next;
    logic [XW:0] dx_ext;  // one extra bit so the difference cannot wrap

    assign dx_ext = {1'b0, dest_x} - {1'b0, current_x};

    always_comb begin
        flags_next.x_plus    = (dest_x > current_x);
        flags_next.x_min     = (dest_x < current_x);
        flags_next.y_plus    = (dest_y > current_y);  // south
        flags_next.y_min     = (dest_y < current_y);  // north
        flags_next.cur_x_odd = current_x[0];
        flags_next.dst_x_odd = dest_x[0];
        // only meaningful when heading east
        flags_next.x_far     = flags_next.x_plus && (dx_ext >= (XW+1)'(2));
    end

    // strobe register
    always_ff @(posedge clk) begin
        if (reset) begin
            dir.valid <= 1'b0;
        end else begin
            dir.valid <= route_req;
        end
    end

    // request context, captured only with a request
    always_ff @(posedge clk) begin
        if (route_req) begin
            dir.alg   <= route_alg;
            dir.flags <= flags_next;
        end
    end

endmodule

/* mesh_pkg.sv */
package mesh_pkg;

    // mesh size
    localparam int NX = 4;  // columns
    localparam int NY = 4;  // rows

    localparam int XW = $clog2(NX);
    localparam int YW = $clog2(NY);

    typedef logic [XW-1:0] x_coord_t;
    typedef logic [YW-1:0] y_coord_t;

    // router ports, north is toward smaller y
    typedef enum logic [2:0] {
        PORT_LOCAL = 3'd0,
        PORT_EAST  = 3'd1,
        PORT_NORTH = 3'd2,
        PORT_WEST  = 3'd3,
        PORT_SOUTH = 3'd4
    } port_e;

    localparam int NUM_PORTS = 5;

    // one bit per port, indexed by port_e
    typedef logic [NUM_PORTS-1:0] port_mask_t;

    // one-hot mask for a single port
    function automatic port_mask_t port_bit(port_e p);
        port_mask_t m;
        m = '0;
        m[p] = 1'b1;
        return m;
    endfunction

endpackage

/* mesh_route_unit.f */
mesh_pkg.sv
route_pkg.sv
dir_if.sv
mesh_dir_stage.sv
port_select_stage.sv
mesh_route_unit.sv
tb_mesh_route_unit.sv

/* mesh_route_unit.sv */
`timescale 1ns/1ps

module mesh_route_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   route_req,    // one-cycle strobe
    input  route_pkg::route_alg_e  route_alg,
    input  mesh_pkg::x_coord_t     current_x,
    input  mesh_pkg::y_coord_t     current_y,
    input  mesh_pkg::x_coord_t     dest_x,
    input  mesh_pkg::y_coord_t     dest_y,
    output logic                   route_valid,  // two cycles after route_req
    output mesh_pkg::port_mask_t   route_ports,
    output route_pkg::route_code_t route_code
);

    // stage 1 to stage 2 pipeline register
    dir_if dir_bus ();

    mesh_dir_stage dir_stage_i (
        .clk       (clk),
        .reset     (reset),
        .route_req (route_req),
        .route_alg (route_alg),
        .current_x (current_x),
        .current_y (current_y),
        .dest_x    (dest_x),
        .dest_y    (dest_y),
        .dir       (dir_bus.producer)
    );

    port_select_stage select_stage_i (
        .clk         (clk),
        .reset       (reset),
        .dir         (dir_bus.consumer),
        .route_valid (route_valid),
        .route_ports (route_ports),
        .route_code  (route_code)
    );

endmodule

/* port_select_stage.sv */
`timescale 1ns/1ps

module port_select_stage (
    input  logic                   clk,
    input  logic                   reset,
    dir_if.consumer                dir,
    output logic                   route_valid,
    output mesh_pkg::port_mask_t   route_ports,
    output route_pkg::route_code_t route_code
);
    import mesh_pkg::*;
    import route_pkg::*;

    dir_flags_t  f;
    port_mask_t  xp;       // productive x port
    port_mask_t  yp;       // productive y port
    logic        aligned;  // only one axis left to travel
    port_mask_t  mask_next;
    route_code_t code_next;

    assign f       = dir.flags;
    assign xp      = x_port(f);
    assign yp      = y_port(f);
    assign aligned = moves_x(f) ^ moves_y(f);

    always_comb begin
        mask_next = '0;
        case (dir.alg)
            ALG_XY: begin
                if (is_local(f)) begin
                    mask_next = port_bit(PORT_LOCAL);
                end else if (moves_x(f)) begin
                    mask_next = xp;  // finish x first
                end else begin
                    mask_next = yp;
                end
            end

            ALG_WEST_FIRST: begin
                if (is_local(f)) begin
                    mask_next = port_bit(PORT_LOCAL);
                end else if (aligned) begin
                    mask_next = xp | yp;
                end else if (f.x_min) begin
                    mask_next = port_bit(PORT_WEST);  // west hops go first
                end else begin
                    mask_next = port_bit(PORT_EAST) | yp;
                end
            end

            ALG_NORTH_LAST: begin
                if (is_local(f)) begin
                    mask_next = port_bit(PORT_LOCAL);
                end else if (aligned) begin
                    mask_next = xp | yp;
                end else if (f.y_min) begin
                    mask_next = xp;  // north only once x is done
                end else begin
                    mask_next = xp | port_bit(PORT_SOUTH);
                end
            end

            ALG_NEGATIVE_FIRST: begin
                if (is_local(f)) begin
                    mask_next = port_bit(PORT_LOCAL);
                end else if (aligned) begin
                    mask_next = xp | yp;
                end else if (f.x_min && f.y_min) begin
                    mask_next = port_bit(PORT_WEST);
                end else if (f.x_min) begin
                    mask_next = port_bit(PORT_WEST) | port_bit(PORT_SOUTH);
                end else if (f.y_min) begin
                    mask_next = port_bit(PORT_EAST) | port_bit(PORT_NORTH);
                end else begin
                    mask_next = port_bit(PORT_SOUTH);
                end
            end

            ALG_ODD_EVEN: begin
                if (is_local(f)) begin
                    mask_next = port_bit(PORT_LOCAL);
                end else if (aligned) begin
                    mask_next = xp | yp;
                end else if (f.x_plus) begin
                    // east-bound, turns out of x only in odd columns
                    if (f.cur_x_odd) begin
                        mask_next = mask_next | yp;
                    end
                    if (f.dst_x_odd || f.x_far) begin
                        mask_next = mask_next | port_bit(PORT_EAST);
                    end
                end else begin
                    // west-bound
                    mask_next = port_bit(PORT_WEST);
                    if (!f.cur_x_odd) begin
                        mask_next = mask_next | yp;  // even column
                    end
                end
            end

            ALG_DUATO: begin
                if (is_local(f)) begin
                    mask_next = port_bit(PORT_LOCAL);
                end else begin
                    mask_next = xp | yp;  // any productive port
                end
            end

            default: begin
                mask_next = '0;  // unknown opcode
            end
        endcase
    end

    // destination code from flags and chosen mask
    always_comb begin
        code_next.x = f.x_plus;
        code_next.y = f.y_min;
        code_next.a = mask_next[PORT_EAST] | mask_next[PORT_WEST];
        code_next.b = mask_next[PORT_NORTH] | mask_next[PORT_SOUTH];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            route_valid <= 1'b0;
        end else begin
            route_valid <= dir.valid;
        end
    end

    // results, updated only for a live request
    always_ff @(posedge clk) begin
        if (dir.valid) begin
            route_ports <= mask_next;
            route_code  <= code_next;
        end
    end

endmodule

/* route_pkg.sv */
package route_pkg;

    // routing algorithm select
    typedef enum logic [2:0] {
        ALG_XY             = 3'd0,
        ALG_WEST_FIRST     = 3'd1,
        ALG_NORTH_LAST     = 3'd2,
        ALG_NEGATIVE_FIRST = 3'd3,
        ALG_ODD_EVEN       = 3'd4,
        ALG_DUATO          = 3'd5
    } route_alg_e;

    // compact destination code for adaptive routers, x is the msb
    typedef struct packed {
        logic x;  // destination lies east
        logic y;  // destination lies north
        logic a;  // an x port is allowed
        logic b;  // a y port is allowed
    } route_code_t;

    typedef struct packed {
        logic x_plus;
        logic x_min;
        logic y_plus;
        logic y_min;
        logic cur_x_odd;
        logic dst_x_odd;
        logic x_far;      // two or more columns east
    } dir_flags_t;

    function automatic logic moves_x(dir_flags_t f);
        return f.x_plus | f.x_min;
    endfunction

    function automatic logic moves_y(dir_flags_t f);
        return f.y_plus | f.y_min;
    endfunction

    function automatic logic is_local(dir_flags_t f);
        return !moves_x(f) && !moves_y(f);
    endfunction

    // productive port on the x axis, empty when aligned
    function automatic mesh_pkg::port_mask_t x_port(dir_flags_t f);
        mesh_pkg::port_mask_t m;
        m = '0;
        m[mesh_pkg::PORT_EAST] = f.x_plus;
        m[mesh_pkg::PORT_WEST] = f.x_min;
        return m;
    endfunction

    // productive port on the y axis
    function automatic mesh_pkg::port_mask_t y_port(dir_flags_t f);
        mesh_pkg::port_mask_t m;
        m = '0;
        m[mesh_pkg::PORT_NORTH] = f.y_min;
        m[mesh_pkg::PORT_SOUTH] = f.y_plus;
        return m;
    endfunction

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the mesh_route_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f mesh_route_unit.f \
    --top-module tb_mesh_route_unit \
    --Mdir obj_dir -o sim_tb
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Done: no errors" <<< "$sim_output"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi

/* tb_mesh_route_unit.sv */
`timescale 1ns/1ps

module tb_mesh_route_unit;
    import mesh_pkg::*;
    import route_pkg::*;

    localparam logic [31:0] RAND_SEED = 32'h195a_b54d;
    localparam int XY_REQS    = 18;   // 2 routers, 9 relations
    localparam int TURN_REQS  = 81;   // 3 algorithms, 3 routers, 9 relations
    localparam int OE_REQS    = 29;
    localparam int RAND_REQS  = 200;
    localparam int TOTAL_REQS = XY_REQS + TURN_REQS + OE_REQS + RAND_REQS;
    localparam int TIMEOUT_NS = TOTAL_REQS * 10 + 2000;

    // port masks written out from the port numbering
    localparam port_mask_t M_LOCAL = 5'b00001;
    localparam port_mask_t M_EAST  = 5'b00010;
    localparam port_mask_t M_NORTH = 5'b00100;
    localparam port_mask_t M_WEST  = 5'b01000;
    localparam port_mask_t M_SOUTH = 5'b10000;

    typedef struct packed {
        logic [31:0] id;
        logic [31:0] due;  // cycle count when the result must show up
        route_alg_e  alg;
        x_coord_t    cx;
        y_coord_t    cy;
        x_coord_t    tx;
        y_coord_t    ty;
        port_mask_t  ports;
        route_code_t code;
    } exp_t;

    logic        clk;
    logic        reset;
    logic        route_req;
    route_alg_e  route_alg;
    x_coord_t    current_x;
    y_coord_t    current_y;
    x_coord_t    dest_x;
    y_coord_t    dest_y;
    logic        route_valid;
    port_mask_t  route_ports;
    route_code_t route_code;

    exp_t exp_q[$];
    int   cyc = 0;
    int   req_count = 0;
    int   checks = 0;
    int   errors = 0;

    mesh_route_unit dut_i (
        .clk         (clk),
        .reset       (reset),
        .route_req   (route_req),
        .route_alg   (route_alg),
        .current_x   (current_x),
        .current_y   (current_y),
        .dest_x      (dest_x),
        .dest_y      (dest_y),
        .route_valid (route_valid),
        .route_ports (route_ports),
        .route_code  (route_code)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;  // rising edges seen so far

    // expected port set from the routing rules
    function automatic port_mask_t model_ports(route_alg_e alg, int cx, int cy, int tx, int ty);
        int dx;
        int dy;
        port_mask_t xp;
        port_mask_t yp;
        port_mask_t m;
        dx = tx - cx;
        dy = ty - cy;
        xp = (dx > 0) ? M_EAST : ((dx < 0) ? M_WEST : '0);
        yp = (dy < 0) ? M_NORTH : ((dy > 0) ? M_SOUTH : '0);
        m = '0;
        if (!(alg inside {ALG_XY, ALG_WEST_FIRST, ALG_NORTH_LAST, ALG_NEGATIVE_FIRST,
                          ALG_ODD_EVEN, ALG_DUATO})) return '0;
        if (dx == 0 && dy == 0) return M_LOCAL;
        if (alg != ALG_XY && (dx == 0 || dy == 0)) return xp | yp;  // single productive port
        case (alg)
            ALG_XY:         m = (dx != 0) ? xp : yp;
            ALG_WEST_FIRST: m = (dx < 0) ? M_WEST : (M_EAST | yp);
            ALG_NORTH_LAST: m = (dy < 0) ? xp : (xp | M_SOUTH);
            ALG_NEGATIVE_FIRST: begin
                if (dx < 0 && dy < 0) m = M_WEST;
                else if (dx < 0) m = M_WEST | M_SOUTH;
                else if (dy < 0) m = M_EAST | M_NORTH;
                else m = M_SOUTH;
            end
            ALG_ODD_EVEN: begin
                if (dx > 0) begin
                    if (cx % 2 == 1) m = m | yp;
                    if (tx % 2 == 1 || dx >= 2) m = m | M_EAST;
                end else begin
                    m = M_WEST;
                    if (cx % 2 == 0) m = m | yp;  // even column may turn
                end
            end
            default: m = xp | yp;  // duato
        endcase
        return m;
    endfunction

    function automatic route_code_t model_code(int dx, int dy, port_mask_t m);
        route_code_t c;
        c.x = (dx > 0);
        c.y = (dy < 0);
        c.a = |(m & (M_EAST | M_WEST));
        c.b = |(m & (M_NORTH | M_SOUTH));
        return c;
    endfunction

    task automatic check_ports(string what, port_mask_t got, port_mask_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s ports %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_code(string what, route_code_t got, route_code_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s code %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_valid(string what, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s route_valid %b, expected %b", $time, what, got, exp);
        end
    endtask

    // call 1ns after a rising edge, returns 1ns after the next one
    task automatic send_req(route_alg_e alg, int cx, int cy, int tx, int ty);
        exp_t e;
        e.id    = req_count;
        e.due   = cyc + 2;  // sampled on the next edge, result registered one edge later
        e.alg   = alg;
        e.cx    = x_coord_t'(cx);
        e.cy    = y_coord_t'(cy);
        e.tx    = x_coord_t'(tx);
        e.ty    = y_coord_t'(ty);
        e.ports = model_ports(alg, cx, cy, tx, ty);
        e.code  = model_code(tx - cx, ty - cy, e.ports);
        exp_q.push_back(e);
        req_count++;
        route_req = 1'b1;
        route_alg = alg;
        current_x = e.cx;
        current_y = e.cy;
        dest_x    = e.tx;
        dest_y    = e.ty;
        @(posedge clk);
        #1;
        route_req = 1'b0;
    endtask

    // waits for outstanding results, bounded
    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 8) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d requests never got a result", exp_q.size());
            exp_q.delete();
        end
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(string name, int errs_before);
        if (errors == errs_before) $display("test %s: passed", name);
        else $display("test %s: FAILED with %0d errors", name, errors - errs_before);
    endtask

    always @(negedge clk) begin : result_monitor
        exp_t e;
        string what;
        if (route_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("route_valid went high at %0t with no request pending", $time);
            end else begin
                e = exp_q.pop_front();
                what = $sformatf("req %0d %s (%0d,%0d)->(%0d,%0d)", e.id, e.alg.name(),
                                 e.cx, e.cy, e.tx, e.ty);
                if (cyc != e.due) begin
                    errors++;
                    $display("%s: result arrived at cycle %0d instead of cycle %0d",
                             what, cyc, e.due);
                end
                check_ports(what, route_ports, e.ports);
                check_code(what, route_code, e.code);
            end
        end
    end

    task automatic run_reset_test();
        int errs;
        errs = errors;
        repeat (15) begin
            @(negedge clk);
            check_valid("during reset", route_valid, 1'b0);
        end
        @(posedge clk);  // sixteenth edge with reset high
        #1;
        reset = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_valid("idle after reset", route_valid, 1'b0);
        end
        @(posedge clk);
        #1;
        report_test("reset", errs);
    endtask

    task automatic run_xy_test();
        int errs;
        int c;
        errs = errors;
        for (c = 1; c <= 2; c++) begin
            for (int dy = -1; dy <= 1; dy++) begin
                for (int dx = -1; dx <= 1; dx++) send_req(ALG_XY, c, c, c + dx, c + dy);
            end
        end
        wait_drain();
        report_test("xy", errs);
    endtask

    task automatic run_turn_test();
        int errs;
        route_alg_e algs[3];
        int cxs[3];
        int cys[3];
        errs = errors;
        algs = '{ALG_WEST_FIRST, ALG_NORTH_LAST, ALG_NEGATIVE_FIRST};
        cxs  = '{1, 2, 1};
        cys  = '{1, 2, 2};
        foreach (algs[a]) begin
            for (int r = 0; r < 3; r++) begin
                for (int dy = -1; dy <= 1; dy++) begin
                    for (int dx = -1; dx <= 1; dx++) begin
                        send_req(algs[a], cxs[r], cys[r], cxs[r] + dx, cys[r] + dy);
                    end
                end
            end
        end
        wait_drain();
        report_test("turn models", errs);
    endtask

    task automatic run_odd_even_test();
        int errs;
        errs = errors;
        // east-bound, every start column and distance, both y directions
        for (int cx = 0; cx <= 2; cx++) begin
            for (int tx = cx + 1; tx <= 3; tx++) begin
                send_req(ALG_ODD_EVEN, cx, 1, tx, 0);
                send_req(ALG_ODD_EVEN, cx, 1, tx, 2);
            end
        end
        // west-bound
        for (int cx = 1; cx <= 3; cx++) begin
            for (int tx = 0; tx < cx; tx++) begin
                send_req(ALG_ODD_EVEN, cx, 1, tx, 0);
                send_req(ALG_ODD_EVEN, cx, 1, tx, 2);
            end
        end
        send_req(ALG_ODD_EVEN, 2, 1, 2, 1);  // self
        send_req(ALG_ODD_EVEN, 2, 1, 3, 1);
        send_req(ALG_ODD_EVEN, 2, 1, 0, 1);
        send_req(ALG_ODD_EVEN, 2, 1, 2, 0);
        send_req(ALG_ODD_EVEN, 2, 1, 2, 3);
        wait_drain();
        report_test("odd-even", errs);
    endtask

    task automatic run_random_test();
        int errs;
        route_alg_e alg;
        errs = errors;
        for (int i = 0; i < RAND_REQS; i++) begin
            alg = route_alg_e'(3'($urandom % 6));
            send_req(alg, $urandom % NX, $urandom % NY, $urandom % NX, $urandom % NY);
        end
        wait_drain();
        report_test("random back-to-back", errs);
    endtask

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, run did not finish", TIMEOUT_NS);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        route_req = 1'b0;
        route_alg = ALG_XY;
        current_x = '0;
        current_y = '0;
        dest_x    = '0;
        dest_y    = '0;
        void'($urandom(RAND_SEED));
        run_reset_test();
        run_xy_test();
        run_turn_test();
        run_odd_even_test();
        run_random_test();
        $display("requests %0d, checks %0d, errors %0d", req_count, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
